//--- tb.f
+incdir+hdl
hdl/noc_pkg.sv
hdl/xbar_req_if.sv
hdl/input_port.sv
hdl/output_arbiter.sv
hdl/crossbar_switch.sv
hdl/mesh_router.sv
verification/clock_gen.sv
verification/mesh_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the router testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f tb.f --top-module mesh_router_tb -o mesh_router_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mesh_router_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verification/mesh_router_tb.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module mesh_router_tb;

  localparam int NP      = `NOC_NUM_PORTS;
  localparam int P_N     = 0;
  localparam int P_S     = 1;
  localparam int P_W     = 2;
  localparam int P_E     = 3;
  localparam int P_L     = 4;
  localparam int N_ROWS  = 14;
  localparam int TIMEOUT = 20 * N_ROWS + 100;

  typedef struct packed {
    int port;   // Input port.
    int dx;
    int dy;
    int gap;    // Idle cycles first. Zero joins the row above.
    int count;  // Flits sent back to back.
    int dest;   // Output by XY routing from router (3,3).
    int lat;    // Check the two-cycle latency.
  } row_t;

  localparam row_t TABLE [N_ROWS] = '{
    '{P_L, 5, 3, 4, 1, P_E, 1},
    '{P_L, 1, 6, 4, 1, P_W, 1},   // X resolves first.
    '{P_L, 3, 6, 4, 1, P_N, 1},
    '{P_L, 3, 0, 4, 1, P_S, 1},
    '{P_N, 3, 3, 4, 1, P_L, 1},
    '{P_W, 6, 1, 4, 1, P_E, 1},
    '{P_E, 0, 5, 4, 1, P_W, 1},
    '{P_S, 3, 7, 4, 1, P_N, 1},
    '{P_N, 3, 3, 4, 6, P_L, 0},   // All network inputs burst into local.
    '{P_S, 3, 3, 0, 6, P_L, 0},
    '{P_W, 3, 3, 0, 6, P_L, 0},
    '{P_E, 3, 3, 0, 6, P_L, 0},
    '{P_W, 3, 5, 20, 8, P_N, 0},  // W and E contend for N until full.
    '{P_E, 3, 6, 0, 8, P_N, 0}
  };

  logic                   clk;
  logic                   reset;
  logic [`NOC_FLIT_W-1:0] flit_in [NP];
  logic [NP-1:0]          valid_in;
  logic [NP-1:0]          full;
  logic [`NOC_FLIT_W-1:0] flit_out [NP];
  logic [NP-1:0]          valid_out;
  logic [31:0]            lfsr_q;
  logic [`NOC_FLIT_W-1:0] exp_flit_q [NP*NP][$];  // Index is source * NP + output.
  int                     exp_cyc_q [NP*NP][$];   // Delivery cycle or -1.
  int                     fair_cnt [NP];
  int                     cycle_cnt = 0;
  int                     checks = 0;
  int                     errors = 0;
  int                     full_waits = 0;

  clock_gen #(.PERIOD(100)) u_clk (.clk_o(clk));

  mesh_router #(.ROUTER_X(3'd3), .ROUTER_Y(3'd3)) mesh_router_inst (
    .clk_i          (clk),
    .reset_i        (reset),
    .n_flit_i       (flit_in[P_N]),
    .n_flit_valid_i (valid_in[P_N]),
    .n_full_o       (full[P_N]),
    .n_flit_o       (flit_out[P_N]),
    .n_flit_valid_o (valid_out[P_N]),
    .s_flit_i       (flit_in[P_S]),
    .s_flit_valid_i (valid_in[P_S]),
    .s_full_o       (full[P_S]),
    .s_flit_o       (flit_out[P_S]),
    .s_flit_valid_o (valid_out[P_S]),
    .w_flit_i       (flit_in[P_W]),
    .w_flit_valid_i (valid_in[P_W]),
    .w_full_o       (full[P_W]),
    .w_flit_o       (flit_out[P_W]),
    .w_flit_valid_o (valid_out[P_W]),
    .e_flit_i       (flit_in[P_E]),
    .e_flit_valid_i (valid_in[P_E]),
    .e_full_o       (full[P_E]),
    .e_flit_o       (flit_out[P_E]),
    .e_flit_valid_o (valid_out[P_E]),
    .l_flit_i       (flit_in[P_L]),
    .l_flit_valid_i (valid_in[P_L]),
    .l_full_o       (full[P_L]),
    .l_flit_o       (flit_out[P_L]),
    .l_flit_valid_o (valid_out[P_L])
  );

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic string port_name(input int p);
    case (p)
      P_N:     return "N";
      P_S:     return "S";
      P_W:     return "W";
      P_E:     return "E";
      default: return "L";
    endcase
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < NP * NP; i++)
      n += exp_flit_q[i].size();
    return n;
  endfunction

  // Flits of input p still held in its FIFO, just after a rising edge.
  function automatic int fifo_level(input int p);
    int n;
    n = 0;
    for (int o = 0; o < NP; o++) begin
      n += exp_flit_q[p * NP + o].size();
      if (valid_out[o] && int'(flit_out[o][9:7]) == p)
        n--;  // Left the FIFO at this edge, not yet scored.
    end
    return n;
  endfunction

  task automatic score_delivery(input int o, input logic [`NOC_FLIT_W-1:0] flit);
    int    src;
    int    idx;
    int    cyc;
    int    diff;
    string tag;
    src = int'(flit[9:7]);  // Source port rides in the payload.
    idx = src * NP + o;
    if (src >= NP) begin
      report_failure($sformatf("output %s carried a flit with source field %0d",
                               port_name(o), src));
    end else if (exp_flit_q[idx].size() == 0) begin
      report_failure($sformatf("output %s delivered a flit from %s that was never sent there",
                               port_name(o), port_name(src)));
    end else begin
      tag = $sformatf("flit from %s on output %s", port_name(src), port_name(o));
      cyc = exp_cyc_q[idx].pop_front();
      check_equal(32'(flit), 32'(exp_flit_q[idx].pop_front()), tag);
      if (cyc >= 0)
        check_equal(32'(cycle_cnt), 32'(cyc), {tag, " delivery cycle"});
      if (o == P_N && (src == P_W || src == P_E)) begin
        fair_cnt[src]++;
        diff = fair_cnt[P_W] - fair_cnt[P_E];
        check_equal(32'(diff >= -1 && diff <= 1), 32'd1, "round robin balance on output N");
      end
    end
  endtask

  // Outputs are stable at the falling edge.
  task automatic watch_outputs();
    forever begin
      @(negedge clk);
      if (!reset) begin
        for (int o = 0; o < NP; o++) begin
          if (valid_out[o])
            score_delivery(o, flit_out[o]);
        end
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Sends the rows first..last in parallel, one flit per port per cycle.
  task automatic send_group(input int first, input int last);
    int                     rem [NP];
    int                     row_of [NP];
    int                     busy;
    int                     idx;
    row_t                   row;
    logic [31:0]            rnd;
    logic [`NOC_FLIT_W-1:0] flit;
    for (int p = 0; p < NP; p++) begin
      rem[p]    = 0;
      row_of[p] = 0;
    end
    for (int r = first; r <= last; r++) begin
      rem[TABLE[r].port]    = TABLE[r].count;
      row_of[TABLE[r].port] = r;
    end
    busy = 1;
    while (busy != 0) begin
      busy = 0;
      for (int p = 0; p < NP; p++) begin
        valid_in[p] = 1'b0;
        check_equal(32'(full[p]), 32'(fifo_level(p) >= `NOC_FIFO_DEPTH),
                    {"full_o of input ", port_name(p)});
        if (rem[p] > 0 && full[p]) begin
          full_waits++;  // Hold off while the FIFO is full.
        end else if (rem[p] > 0) begin
          row = TABLE[row_of[p]];
          draw_bits(7, rnd);
          flit        = {3'(row.dx), 3'(row.dy), 3'(p), rnd[6:0]};
          flit_in[p]  = flit;
          valid_in[p] = 1'b1;
          idx         = p * NP + row.dest;
          exp_flit_q[idx].push_back(flit);
          exp_cyc_q[idx].push_back(row.lat != 0 ? cycle_cnt + 3 : -1);
          rem[p]--;
        end
        if (rem[p] > 0)
          busy = 1;
      end
      @(posedge clk);
      #1;
    end
    valid_in = '0;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int          r;
    int          last;
    logic [31:0] rnd;
    reset    = 1'b1;
    valid_in = '0;
    lfsr_q   = 32'h4364_75d1;
    for (int p = 0; p < NP; p++) begin
      flit_in[p]  = '0;
      fair_cnt[p] = 0;
    end
    fork
      watch_outputs();
    join_none
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    @(negedge clk);
    check_equal(32'(valid_out), 32'd0, "flit_valid_o after reset");
    check_equal(32'(full), 32'd0, "full_o after reset");
    @(posedge clk);
    #1;
    r = 0;
    while (r < N_ROWS) begin
      last = r;
      while (last + 1 < N_ROWS && TABLE[last + 1].gap == 0)
        last++;
      draw_bits(2, rnd);
      idle_cycles(TABLE[r].gap + int'(rnd[1:0]));
      send_group(r, last);
      r = last + 1;
    end
    while (pending_count() > 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    check_equal(32'(full_waits > 0), 32'd1, "full_o under sustained contention");
    $display("mesh_router_tb finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- verification/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;  // Rising edges at 50, 150, 250 ns.
  end

endmodule

//--- hdl/mesh_router.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module mesh_router #(
  parameter logic [`NOC_COORD_W-1:0] ROUTER_X = '0,
  parameter logic [`NOC_COORD_W-1:0] ROUTER_Y = '0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic [`NOC_FLIT_W-1:0] n_flit_i,
  input  logic                   n_flit_valid_i,
  output logic                   n_full_o,
  output logic [`NOC_FLIT_W-1:0] n_flit_o,
  output logic                   n_flit_valid_o,

  input  logic [`NOC_FLIT_W-1:0] s_flit_i,
  input  logic                   s_flit_valid_i,
  output logic                   s_full_o,
  output logic [`NOC_FLIT_W-1:0] s_flit_o,
  output logic                   s_flit_valid_o,

  input  logic [`NOC_FLIT_W-1:0] w_flit_i,
  input  logic                   w_flit_valid_i,
  output logic                   w_full_o,
  output logic [`NOC_FLIT_W-1:0] w_flit_o,
  output logic                   w_flit_valid_o,

  input  logic [`NOC_FLIT_W-1:0] e_flit_i,
  input  logic                   e_flit_valid_i,
  output logic                   e_full_o,
  output logic [`NOC_FLIT_W-1:0] e_flit_o,
  output logic                   e_flit_valid_o,

  input  logic [`NOC_FLIT_W-1:0] l_flit_i,
  input  logic                   l_flit_valid_i,
  output logic                   l_full_o,
  output logic [`NOC_FLIT_W-1:0] l_flit_o,
  output logic                   l_flit_valid_o
);
  import noc_pkg::*;

  xbar_req_if req_n_if ();
  xbar_req_if req_s_if ();
  xbar_req_if req_w_if ();
  xbar_req_if req_e_if ();
  xbar_req_if req_l_if ();

  input_port #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .IN_PORT(PORT_N)) u_in_n (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_i       (n_flit_i),
    .flit_valid_i (n_flit_valid_i),
    .full_o       (n_full_o),
    .req          (req_n_if.requester)
  );

  input_port #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .IN_PORT(PORT_S)) u_in_s (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_i       (s_flit_i),
    .flit_valid_i (s_flit_valid_i),
    .full_o       (s_full_o),
    .req          (req_s_if.requester)
  );

  input_port #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .IN_PORT(PORT_W)) u_in_w (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_i       (w_flit_i),
    .flit_valid_i (w_flit_valid_i),
    .full_o       (w_full_o),
    .req          (req_w_if.requester)
  );

  input_port #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .IN_PORT(PORT_E)) u_in_e (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_i       (e_flit_i),
    .flit_valid_i (e_flit_valid_i),
    .full_o       (e_full_o),
    .req          (req_e_if.requester)
  );

  input_port #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y), .IN_PORT(PORT_L)) u_in_l (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_i       (l_flit_i),
    .flit_valid_i (l_flit_valid_i),
    .full_o       (l_full_o),
    .req          (req_l_if.requester)
  );

  crossbar_switch u_xbar (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_n          (req_n_if.switch),
    .req_s          (req_s_if.switch),
    .req_w          (req_w_if.switch),
    .req_e          (req_e_if.switch),
    .req_l          (req_l_if.switch),
    .n_flit_o       (n_flit_o),
    .n_flit_valid_o (n_flit_valid_o),
    .s_flit_o       (s_flit_o),
    .s_flit_valid_o (s_flit_valid_o),
    .w_flit_o       (w_flit_o),
    .w_flit_valid_o (w_flit_valid_o),
    .e_flit_o       (e_flit_o),
    .e_flit_valid_o (e_flit_valid_o),
    .l_flit_o       (l_flit_o),
    .l_flit_valid_o (l_flit_valid_o)
  );

endmodule

//--- hdl/crossbar_switch.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module crossbar_switch (
  input  logic           clk_i,
  input  logic           reset_i,
  xbar_req_if.switch     req_n,
  xbar_req_if.switch     req_s,
  xbar_req_if.switch     req_w,
  xbar_req_if.switch     req_e,
  xbar_req_if.switch     req_l,
  output noc_pkg::flit_t n_flit_o,
  output logic           n_flit_valid_o,
  output noc_pkg::flit_t s_flit_o,
  output logic           s_flit_valid_o,
  output noc_pkg::flit_t w_flit_o,
  output logic           w_flit_valid_o,
  output noc_pkg::flit_t e_flit_o,
  output logic           e_flit_valid_o,
  output noc_pkg::flit_t l_flit_o,
  output logic           l_flit_valid_o
);
  import noc_pkg::*;

  flit_t                     in_flit [`NOC_NUM_PORTS];
  logic                      in_valid [`NOC_NUM_PORTS];
  port_e                     in_port [`NOC_NUM_PORTS];
  logic [`NOC_NUM_PORTS-1:0] grant_in;
  logic [`NOC_NUM_PORTS-1:0] req_vec [`NOC_NUM_PORTS];    // Indexed by output.
  logic [`NOC_NUM_PORTS-1:0] grant_vec [`NOC_NUM_PORTS];  // Indexed by output.
  logic                      grant_valid [`NOC_NUM_PORTS];
  port_e                     grant_idx [`NOC_NUM_PORTS];
  flit_t                     out_flit_q [`NOC_NUM_PORTS];
  logic                      out_valid_q [`NOC_NUM_PORTS];

  assign in_flit[PORT_N] = req_n.flit;
  assign in_flit[PORT_S] = req_s.flit;
  assign in_flit[PORT_W] = req_w.flit;
  assign in_flit[PORT_E] = req_e.flit;
  assign in_flit[PORT_L] = req_l.flit;

  assign in_valid[PORT_N] = req_n.req_valid;
  assign in_valid[PORT_S] = req_s.req_valid;
  assign in_valid[PORT_W] = req_w.req_valid;
  assign in_valid[PORT_E] = req_e.req_valid;
  assign in_valid[PORT_L] = req_l.req_valid;

  assign in_port[PORT_N] = req_n.req_port;
  assign in_port[PORT_S] = req_s.req_port;
  assign in_port[PORT_W] = req_w.req_port;
  assign in_port[PORT_E] = req_e.req_port;
  assign in_port[PORT_L] = req_l.req_port;

  // Column o collects the inputs routed to output o.
  always_comb begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      for (int i = 0; i < `NOC_NUM_PORTS; i++)
        req_vec[o][i] = in_valid[i] && (in_port[i] == port_e'(o));
    end
  end

  for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : g_arb
    output_arbiter u_arb (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .req_vec_i     (req_vec[o]),
      .grant_vec_o   (grant_vec[o]),
      .grant_valid_o (grant_valid[o]),
      .grant_idx_o   (grant_idx[o])
    );
  end

  // An input requests one output, so at most one column grants it.
  always_comb begin
    grant_in = '0;
    for (int o = 0; o < `NOC_NUM_PORTS; o++)
      grant_in = grant_in | grant_vec[o];
  end

  assign req_n.grant = grant_in[PORT_N];
  assign req_s.grant = grant_in[PORT_S];
  assign req_w.grant = grant_in[PORT_W];
  assign req_e.grant = grant_in[PORT_E];
  assign req_l.grant = grant_in[PORT_L];

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      if (grant_valid[o])
        out_flit_q[o] <= in_flit[grant_idx[o]];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
      if (reset_i)
        out_valid_q[o] <= 1'b0;
      else
        out_valid_q[o] <= grant_valid[o];  // One-cycle pulse per grant.
    end
  end

  assign n_flit_o       = out_flit_q[PORT_N];
  assign s_flit_o       = out_flit_q[PORT_S];
  assign w_flit_o       = out_flit_q[PORT_W];
  assign e_flit_o       = out_flit_q[PORT_E];
  assign l_flit_o       = out_flit_q[PORT_L];
  assign n_flit_valid_o = out_valid_q[PORT_N];
  assign s_flit_valid_o = out_valid_q[PORT_S];
  assign w_flit_valid_o = out_valid_q[PORT_W];
  assign e_flit_valid_o = out_valid_q[PORT_E];
  assign l_flit_valid_o = out_valid_q[PORT_L];

endmodule

//--- hdl/output_arbiter.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module output_arbiter (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic [`NOC_NUM_PORTS-1:0] req_vec_i,
  output logic [`NOC_NUM_PORTS-1:0] grant_vec_o,
  output logic                      grant_valid_o,
  output noc_pkg::port_e            grant_idx_o
);
  import noc_pkg::*;

  port_e ptr_q;  // Highest priority input.
  port_e ptr_next;

  // First requester at or after the pointer wins.
  always_comb begin
    int unsigned idx;
    logic        found;
    grant_vec_o = '0;
    grant_idx_o = PORT_N;
    found       = 1'b0;
    for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
      idx = (int'(ptr_q) + i) % `NOC_NUM_PORTS;
      if (!found && req_vec_i[idx]) begin
        found            = 1'b1;
        grant_vec_o[idx] = 1'b1;
        grant_idx_o      = port_e'(idx);
      end
    end
    grant_valid_o = found;
  end

  assign ptr_next = (grant_idx_o == PORT_L) ? PORT_N : port_e'(grant_idx_o + 1);

  always_ff @(posedge clk_i) begin
    if (reset_i)
      ptr_q <= PORT_N;
    else if (grant_valid_o)
      ptr_q <= ptr_next;  // Winner drops to lowest priority.
  end

  a_grant_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_vec_o) && ((grant_vec_o & ~req_vec_i) == '0));

endmodule

//--- hdl/input_port.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module input_port #(
  parameter logic [`NOC_COORD_W-1:0] ROUTER_X = '0,
  parameter logic [`NOC_COORD_W-1:0] ROUTER_Y = '0,
  parameter noc_pkg::port_e IN_PORT = noc_pkg::PORT_L
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  noc_pkg::flit_t    flit_i,
  input  logic              flit_valid_i,
  output logic              full_o,
  xbar_req_if.requester     req
);
  import noc_pkg::*;

  localparam int PTR_W = $clog2(`NOC_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`NOC_FIFO_DEPTH + 1);

  flit_t            mem_q [`NOC_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             fresh_q;  // Tail entry was written at the last edge.
  logic             wr_en;
  logic             rd_en;
  flit_t            head;
  port_e            route;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`NOC_FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o = (count_q == CNT_W'(`NOC_FIFO_DEPTH));
  assign wr_en  = flit_valid_i & ~full_o;
  assign rd_en  = req.grant;
  assign head   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en)
      mem_q[wr_ptr_q] <= flit_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      fresh_q  <= 1'b0;
    end else begin
      if (wr_en)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (rd_en)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
      fresh_q <= wr_en;
    end
  end

  // XY routing, X first.
  always_comb begin
    if (head.dest_x > ROUTER_X)
      route = PORT_E;
    else if (head.dest_x < ROUTER_X)
      route = PORT_W;
    else if (head.dest_y > ROUTER_Y)
      route = PORT_N;
    else if (head.dest_y < ROUTER_Y)
      route = PORT_S;
    else
      route = PORT_L;
  end

  // A fresh entry only requests one cycle after its write.
  assign req.req_valid = (count_q > CNT_W'(fresh_q));
  assign req.flit      = head;
  assign req.req_port  = route;

  a_no_uturn: assert property (@(posedge clk_i) disable iff (reset_i)
    (req.req_valid && IN_PORT != PORT_L) |-> req.req_port != IN_PORT);

  a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
    flit_valid_i |-> !full_o);

endmodule

//--- hdl/xbar_req_if.sv
`timescale 1ns/10ps

interface xbar_req_if;
  import noc_pkg::*;

  flit_t flit;       // Head flit of the input FIFO.
  logic  req_valid;  // Head flit is waiting for its output.
  port_e req_port;   // Output chosen by XY routing.
  logic  grant;      // Head leaves the FIFO at the next edge.

  modport requester (
    output flit,
    output req_valid,
    output req_port,
    input  grant
  );

  modport switch (
    input  flit,
    input  req_valid,
    input  req_port,
    output grant
  );

endinterface

//--- hdl/noc_pkg.sv
`include "noc_defines.svh"

package noc_pkg;

  // Router ports, also used as route results and arbiter indices.
  typedef enum logic [$clog2(`NOC_NUM_PORTS)-1:0] {
    PORT_N = 0,
    PORT_S = 1,
    PORT_W = 2,
    PORT_E = 3,
    PORT_L = 4
  } port_e;

  // Single-flit packet.
  typedef struct packed {
    logic [`NOC_COORD_W-1:0]   dest_x;   // Bits 15:13.
    logic [`NOC_COORD_W-1:0]   dest_y;   // Bits 12:10.
    logic [`NOC_PAYLOAD_W-1:0] payload;  // Bits 9:0.
  } flit_t;

endpackage

//--- hdl/noc_defines.svh
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Flit layout, {dest_x, dest_y, payload}.
`define NOC_FLIT_W     16
`define NOC_COORD_W    3
`define NOC_PAYLOAD_W  10

// Entries in each input FIFO.
`define NOC_FIFO_DEPTH 4

// N, S, W, E and local.
`define NOC_NUM_PORTS  5

`endif
